//--- list.f
+incdir+include
verilog/core_pkg.sv
verilog/core_settings_regs.sv
verilog/pll_reconfig_seq.sv
verilog/video_slot_out.sv
verilog/rtc_packer.sv
verilog/core_top.sv
verification/core_assert.sv
verification/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core testbench with verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f list.f --top-module core_tb -o core_sim
./obj_dir/core_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- verification/core_testdata.txt
# op a b c d, hex. 1 wr: addr data settings reset_len  2 sram: size data {wren,addr} 0
# 3 rtc: date time toggle word  4 pix: rgb count snap slot  5 pal: value addrs data hold
1 004 5 0A000000 0
1 008 A7 0B4E0000 0
1 00C 3 0B4E6000 0
1 000 1 2B4E6000 0
1 100 1 2B4E6800 0
1 104 3 2B4E6E00 0
1 108 5C 2B4E6EB8 0
1 200 1 2B4E6EB9 0
1 300 FF 2B4E6EB9 0
1 050 0 2B4E6EB9 20
2 0 0 403 0
2 3 2000 403 0
2 9 80000 403 0
3 240615 123456 1 0001240615123456
3 240616 123456 1 0001240616123456
3 240616 123457 0 0001240616123457
4 102030 6 42 6000
4 A0B0C0 4 43 2000
5 1 001F02 0 14
5 0 001F02 0 14

//--- verification/core_tb.sv
//////////////////////////////////////////////////
// testbench for the console control block
// replays the testdata file against core_top and
// prints error counts in a closing line
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_config.svh"

module core_tb
  import core_pkg::*;
();

  localparam int wait_limit = 200;

  logic           clk_74a;
  logic           pll_core_locked;
  bridge_addr_t   bridge_addr;
  logic           bridge_wr;
  bridge_data_t   bridge_wr_data;
  logic [3:0]     sram_size;
  bridge_data_t   rtc_date;
  bridge_data_t   rtc_time;
  video_in_t      video_in;
  snap_index_t    snap_index;
  logic           cfg_waitrequest;
  core_settings_t settings;
  logic           core_reset;
  datatable_t     datatable;
  rtc_t           rtc;
  logic           cfg_write;
  logic [5:0]     cfg_address;
  bridge_data_t   cfg_data;
  logic           pll_reset;
  rgb_t           video_rgb;
  logic           video_de;

  // settings word the host should see after the last write
  core_settings_t settings_exp;

  int check_count = 0;
  int error_count = 0;

  core_top core_top_inst (.*);

  initial begin
    clk_74a = 1'b0;
    forever #2 clk_74a = ~clk_74a;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    error_count++;
  endtask

  //////////////////////////////////////////////////
  // one task per opcode

  // bridge write, whole settings word compared
  task automatic write_setting(input logic [63:0] a, b, c, d);
    int held;
    held = 0;
    bridge_addr    = a[31:0];
    bridge_wr_data = b[31:0];
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    check_value("settings", 64'(settings), c);
    settings_exp = c[$bits(core_settings_t)-1:0];
    if (d == 0) begin
      check_value("core_reset", 64'(core_reset), 64'h0);
    end else begin
      // hold-off length in cycles
      while (core_reset && held < wait_limit) begin
        held++;
        @(negedge clk_74a);
      end
      if (core_reset) report_timeout("core_reset to fall");
      else check_value("core_reset cycles", 64'(held), d);
    end
  endtask

  task automatic apply_sram_size(input logic [63:0] a, b, c);
    sram_size = a[3:0];
    @(negedge clk_74a);
    check_value("datatable.data", 64'(datatable.data), b);
    check_value("datatable.wren_addr", 64'({datatable.wren, datatable.addr}), c);
  endtask

  task automatic apply_rtc(input logic [63:0] a, b, c, d);
    rtc_date = a[31:0];
    rtc_time = b[31:0];
    @(negedge clk_74a);
    check_value("rtc.toggle", 64'(rtc.toggle), c);
    check_value("rtc", rtc[63:0], d);
  endtask

  // vs pulse latches the snap index, then one active run
  task automatic run_pixels(input logic [63:0] a, b, c, d);
    int i;
    video_in.vs = 1'b1;
    snap_index  = c[7:0];
    @(negedge clk_74a);
    video_in.vs = 1'b0;
    // index moves on after the edge
    snap_index  = ~c[7:0];
    for (i = 0; i < int'(b); i++) begin
      video_in.de  = 1'b1;
      video_in.rgb = a[23:0] + 24'(i);
      @(negedge clk_74a);
      check_value("video_de", 64'(video_de), 64'h1);
      check_value("video_rgb", 64'(video_rgb), 64'(a[23:0] + 24'(i)));
    end
    video_in.de  = 1'b0;
    video_in.rgb = '0;
    @(negedge clk_74a);
    // slot word on the first blank pixel
    check_value("video_de", 64'(video_de), 64'h0);
    check_value("video_rgb", 64'(video_rgb), d);
  endtask

  // pal write, three reconfig writes, busy stub, pll reset hold
  task automatic change_pal(input logic [63:0] a, b, c, d);
    logic [5:0] exp_addr [3];
    int k;
    int waited;
    int busy;
    int held;
    exp_addr[0] = b[21:16];
    exp_addr[1] = b[13:8];
    exp_addr[2] = b[5:0];
    busy = 3 + int'($urandom % 8);
    bridge_addr    = `CORE_ADDR_PAL;
    bridge_wr_data = a[31:0];
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    // only the pal field moves
    settings_exp.pal = a[0];
    check_value("settings", 64'(settings), 64'(settings_exp));
    for (k = 0; k < 3; k++) begin
      waited = 0;
      while (!cfg_write && waited < wait_limit) begin
        waited++;
        @(negedge clk_74a);
      end
      if (!cfg_write) begin
        report_timeout("cfg_write pulse");
        return;
      end
      check_value("cfg_address", 64'(cfg_address), 64'(exp_addr[k]));
      check_value("cfg_data", 64'(cfg_data), c);
      if (k < 2) @(negedge clk_74a);
    end
    // controller busy for a random stretch
    cfg_waitrequest = 1'b1;
    repeat (busy) begin
      @(negedge clk_74a);
      check_value("pll_reset", 64'(pll_reset), 64'h0);
    end
    cfg_waitrequest = 1'b0;
    waited = 0;
    while (!pll_reset && waited < wait_limit) begin
      waited++;
      @(negedge clk_74a);
    end
    if (!pll_reset) begin
      report_timeout("pll_reset to rise");
      return;
    end
    held = 0;
    while (pll_reset && held < wait_limit) begin
      held++;
      @(negedge clk_74a);
    end
    if (pll_reset) report_timeout("pll_reset to fall");
    else check_value("pll_reset cycles", 64'(held), d);
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int fd;
    int fields;
    string line;
    logic [7:0]  op;
    logic [63:0] a, b, c, d;
    void'($urandom(32'hd88));
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    sram_size       = '0;
    rtc_date        = '0;
    rtc_time        = '0;
    video_in        = '0;
    snap_index      = '0;
    cfg_waitrequest = 1'b0;
    settings_exp    = '0;
    repeat (5) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    @(negedge clk_74a);
    // state right after reset
    check_value("settings", 64'(settings), 64'h0);
    check_value("core_reset", 64'(core_reset), 64'h0);
    check_value("pll_reset", 64'(pll_reset), 64'h0);
    check_value("cfg_write", 64'(cfg_write), 64'h0);
    check_value("video_de", 64'(video_de), 64'h0);

    fd = $fopen("verification/core_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      error_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h", op, a, b, c, d);
          if (fields != 5) begin
            $display("malformed stimulus line: %s", line);
            error_count++;
          end else begin
            case (op)
              8'h1: write_setting(a, b, c, d);
              8'h2: apply_sram_size(a, b, c);
              8'h3: apply_rtc(a, b, c, d);
              8'h4: run_pixels(a, b, c, d);
              8'h5: change_pal(a, b, c, d);
              default: begin
                $display("unknown opcode in stimulus line: %s", line);
                error_count++;
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end

    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verification/core_assert.sv
//////////////////////////////////////////////////
// protocol checks on the control block top
// bound into core_top from the testbench build
//////////////////////////////////////////////////

`timescale 1ns/1ps

module core_assert (
  input logic clk_74a,
  input logic pll_core_locked,
  input logic cfg_write,
  input logic pll_reset,
  input logic video_de
);

  // reconfig writes are single cycle strobes
  write_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    cfg_write |=> !cfg_write)
    else $error("cfg_write high on two cycles in a row");

  // no register writes while the pll is held in reset
  reset_no_write: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !(pll_reset && cfg_write))
    else $error("pll_reset and cfg_write high together");

  // video quiet while the core clock is not locked
  de_in_reset: assert property (@(posedge clk_74a)
    !pll_core_locked |-> !video_de)
    else $error("video_de high during reset");

endmodule

bind core_top core_assert core_assert_inst (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .cfg_write      (cfg_write),
  .pll_reset      (pll_reset),
  .video_de       (video_de)
);

//--- verilog/core_top.sv
//////////////////////////////////////////////////
// top of the console control block
// connects settings, pll sequencer, video stage
// and rtc packer, all on clk_74a
//////////////////////////////////////////////////

`timescale 1ns/1ps

module core_top
  import core_pkg::*;
(
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  // bridge
  input  bridge_addr_t   bridge_addr,
  input  logic           bridge_wr,
  input  bridge_data_t   bridge_wr_data,
  input  logic [3:0]     sram_size,
  // host date and time
  input  bridge_data_t   rtc_date,
  input  bridge_data_t   rtc_time,
  // video from the core
  input  video_in_t      video_in,
  input  snap_index_t    snap_index,
  // pll reconfig controller
  input  logic           cfg_waitrequest,
  output core_settings_t settings,
  output logic           core_reset,
  output datatable_t     datatable,
  output rtc_t           rtc,
  output logic           cfg_write,
  output logic [5:0]     cfg_address,
  output bridge_data_t   cfg_data,
  output logic           pll_reset,
  output rgb_t           video_rgb,
  output logic           video_de
);

  core_settings_regs core_settings_regs_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .sram_size      (sram_size),
    .settings       (settings),
    .core_reset     (core_reset),
    .datatable      (datatable)
  );

  // video standard drives the pll reprogramming
  pll_reconfig_seq pll_reconfig_seq_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .pal            (settings.pal),
    .cfg_waitrequest(cfg_waitrequest),
    .cfg_write      (cfg_write),
    .cfg_address    (cfg_address),
    .cfg_data       (cfg_data),
    .pll_reset      (pll_reset)
  );

  video_slot_out video_slot_out_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_in       (video_in),
    .snap_index     (snap_index),
    .use_4_3_video  (settings.use_4_3_video),
    .video_rgb      (video_rgb),
    .video_de       (video_de)
  );

  rtc_packer rtc_packer_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rtc_date       (rtc_date),
    .rtc_time       (rtc_time),
    .rtc            (rtc)
  );

endmodule

//--- verilog/rtc_packer.sv
//////////////////////////////////////////////////
// rtc word packer
// packs host date and time into the core word,
// toggle flips on every new time value
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rtc_packer
  import core_pkg::*;
(
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  input  bridge_data_t rtc_date,
  input  bridge_data_t rtc_time,
  output rtc_t         rtc
);

  bridge_data_t time_prev;
  logic         toggle;
  logic         toggle_next;

  // date-only changes leave the toggle alone
  assign toggle_next = toggle ^ (rtc_time != time_prev);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      time_prev <= '0;
      toggle    <= 1'b0;
      rtc       <= '0;
    end else begin
      time_prev  <= rtc_time;
      toggle     <= toggle_next;
      rtc.toggle <= toggle_next;
      rtc.zero   <= 8'd0;
      // weekday not supported, fixed at 1
      rtc.weekday <= 8'd1;
      // low byte of the year only
      rtc.year   <= rtc_date[23:16];
      rtc.month  <= rtc_date[15:8];
      rtc.day    <= rtc_date[7:0];
      rtc.hour   <= rtc_time[23:16];
      rtc.minute <= rtc_time[15:8];
      rtc.second <= rtc_time[7:0];
    end
  end

endmodule

//--- verilog/video_slot_out.sv
//////////////////////////////////////////////////
// video output stage
// registers the pixel stream and puts the slot
// word on the first blank pixel after each line
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_config.svh"

module video_slot_out
  import core_pkg::*;
(
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  video_in_t   video_in,
  input  snap_index_t snap_index,
  input  logic        use_4_3_video,
  output rgb_t        video_rgb,
  output logic        video_de
);

  logic        vs_prev;
  snap_index_t snap_latched;
  rgb_t        slot_word;

  // slot word, only two flag bits set
  always_comb begin
    slot_word                       = '0;
    slot_word[`VIDEO_SLOT_SNAP_BIT] = ~snap_latched[0];
    slot_word[`VIDEO_SLOT_43_BIT]   = use_4_3_video;
  end

  // video_de doubles as the previous de
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      vs_prev  <= 1'b0;
      video_de <= 1'b0;
    end else begin
      vs_prev  <= video_in.vs;
      video_de <= video_in.de;
    end
  end

  always_ff @(posedge clk_74a) begin
    // snap index taken at vsync rise
    if (video_in.vs && !vs_prev) begin
      snap_latched <= snap_index;
    end

    if (video_in.de) begin
      video_rgb <= video_in.rgb;
    end else if (video_de) begin
      // first blank pixel after the run
      video_rgb <= slot_word;
    end
  end

endmodule

//--- verilog/pll_reconfig_seq.sv
//////////////////////////////////////////////////
// fractional pll reconfig sequencer
// watches the video standard and, on a change,
// writes the reconfig registers then resets pll
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_config.svh"

module pll_reconfig_seq
  import core_pkg::*;
(
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  input  logic         pal,
  input  logic         cfg_waitrequest,
  output logic         cfg_write,
  output logic [5:0]   cfg_address,
  output bridge_data_t cfg_data,
  output logic         pll_reset
);

  localparam int CNT_W = $clog2(`PLL_RESET_CYCLES + 1);

  pll_step_e        step;
  // standard the pll is currently set up for
  logic             pal_prev;
  // quiet cycle flag in write steps, hold count in reset step
  logic [CNT_W-1:0] step_count;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      step        <= step_idle;
      pal_prev    <= 1'b0;
      step_count  <= '0;
      cfg_write   <= 1'b0;
      cfg_address <= '0;
      cfg_data    <= '0;
      pll_reset   <= 1'b0;
    end else begin
      // write is a single cycle strobe
      cfg_write <= 1'b0;

      case (step)
        step_idle: begin
          // changes during a sequence are only seen back here
          if (pal != pal_prev) begin
            pal_prev    <= pal;
            step        <= step_write_mode;
            step_count  <= '0;
            cfg_write   <= 1'b1;
            cfg_address <= 6'(`PLL_ADDR_MODE);
            cfg_data    <= '0;
          end
        end

        step_write_mode: begin
          if (step_count == '0) begin
            step_count <= CNT_W'(1);
          end else begin
            // mif address next
            step        <= step_write_mif;
            step_count  <= '0;
            cfg_write   <= 1'b1;
            cfg_address <= 6'(`PLL_ADDR_MIF);
            cfg_data    <= '0;
          end
        end

        step_write_mif: begin
          if (step_count == '0) begin
            step_count <= CNT_W'(1);
          end else begin
            // kick off the reconfig
            step        <= step_write_start;
            step_count  <= '0;
            cfg_write   <= 1'b1;
            cfg_address <= 6'(`PLL_ADDR_START);
            cfg_data    <= '0;
          end
        end

        step_write_start: begin
          if (step_count == '0) begin
            step_count <= CNT_W'(1);
          end else begin
            step <= step_wait_done;
          end
        end

        step_wait_done: begin
          // controller busy while waitrequest is up
          if (!cfg_waitrequest) begin
            step       <= step_reset_hold;
            step_count <= '0;
            pll_reset  <= 1'b1;
          end
        end

        step_reset_hold: begin
          if (step_count == CNT_W'(`PLL_RESET_CYCLES - 1)) begin
            pll_reset <= 1'b0;
            step      <= step_idle;
          end else begin
            step_count <= step_count + 1'b1;
          end
        end

        default: step <= step_idle;
      endcase
    end
  end

endmodule

//--- verilog/core_settings_regs.sv
//////////////////////////////////////////////////
// host settings register file
// decodes bridge writes into the settings struct,
// times the soft reset and forms the save entry
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_config.svh"

module core_settings_regs
  import core_pkg::*;
(
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  bridge_addr_t   bridge_addr,
  input  logic           bridge_wr,
  input  bridge_data_t   bridge_wr_data,
  input  logic [3:0]     sram_size,
  output core_settings_t settings,
  output logic           core_reset,
  output datatable_t     datatable
);

  localparam int RST_CNT_W = $clog2(`CORE_RESET_DELAY + 1);

  logic [RST_CNT_W-1:0] reset_count;

  //////////////////////////////////////////////////
  // bridge write decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings    <= '0;
      reset_count <= '0;
    end else begin
      // hold-off counts down to zero
      if (reset_count != '0) begin
        reset_count <= reset_count - 1'b1;
      end

      if (bridge_wr) begin
        case (bridge_addr)
          `CORE_ADDR_DOWNLOAD:  settings.rom_download <= bridge_wr_data[0];
          `CORE_ADDR_ROM_SIZE:  settings.rom_size <= bridge_wr_data[3:0];
          `CORE_ADDR_ROM_TYPE:  settings.rom_type <= bridge_wr_data[7:0];
          `CORE_ADDR_RAM_SIZE:  settings.ram_size <= bridge_wr_data[3:0];
          `CORE_ADDR_PAL:       settings.pal <= bridge_wr_data[0];
          // reload wins over the countdown
          `CORE_ADDR_RESET:     reset_count <= RST_CNT_W'(`CORE_RESET_DELAY);
          `CORE_ADDR_MULTITAP:  settings.multitap_enabled <= bridge_wr_data[0];
          `CORE_ADDR_LIGHTGUN: begin
            // enable and type share one word
            settings.lightgun_enabled <= bridge_wr_data[0];
            settings.lightgun_type    <= bridge_wr_data[1];
          end
          `CORE_ADDR_AIM_SPEED: settings.lightgun_aim_speed <= bridge_wr_data[7:0];
          `CORE_ADDR_VIDEO_4_3: settings.use_4_3_video <= bridge_wr_data[0];
          default: begin
            // unlisted address, nothing changes
          end
        endcase
      end
    end
  end

  // high for every nonzero count, so exactly the delay length
  assign core_reset = (reset_count != '0);

  //////////////////////////////////////////////////
  // save size entry, rewritten every cycle

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable <= '0;
    end else begin
      datatable.wren <= 1'b1;
      datatable.addr <= 10'(`DATATABLE_SAVE_ADDR);
      // size code 0 means no save ram
      if (sram_size != 4'd0) begin
        datatable.data <= 32'(`SAVE_SIZE_UNIT) << sram_size;
      end else begin
        datatable.data <= '0;
      end
    end
  end

endmodule

//--- verilog/core_pkg.sv
//////////////////////////////////////////////////
// shared types of the console control block
// imported by wildcard in each module header
//////////////////////////////////////////////////

package core_pkg;

  // bridge bus words
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // video words
  typedef logic [23:0] rgb_t;
  typedef logic [7:0]  snap_index_t;

  // settings written by the host, msb first
  typedef struct packed {
    logic       rom_download;
    logic [3:0] rom_size;
    logic [7:0] rom_type;
    logic [3:0] ram_size;
    logic       pal;
    logic       multitap_enabled;
    logic       lightgun_enabled;
    logic       lightgun_type;
    logic [7:0] lightgun_aim_speed;
    logic       use_4_3_video;
  } core_settings_t;

  // one write into the host data table
  typedef struct packed {
    logic         wren;
    logic [9:0]   addr;
    bridge_data_t data;
  } datatable_t;

  // 65-bit rtc word as the core expects it
  typedef struct packed {
    logic       toggle;
    logic [7:0] zero;
    logic [7:0] weekday;
    logic [7:0] year;
    logic [7:0] month;
    logic [7:0] day;
    logic [7:0] hour;
    logic [7:0] minute;
    logic [7:0] second;
  } rtc_t;

  // pixel stream from the core
  typedef struct packed {
    logic de;
    logic vs;
    rgb_t rgb;
  } video_in_t;

  // pll reconfig sequencer steps
  typedef enum logic [2:0] {
    step_idle,
    step_write_mode,
    step_write_mif,
    step_write_start,
    step_wait_done,
    step_reset_hold
  } pll_step_e;

endpackage

//--- include/core_config.svh
//////////////////////////////////////////////////
// constants for the console control block
// include in any module that decodes bridge
// addresses, times resets or builds slot words
//////////////////////////////////////////////////

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// bridge settings addresses
`define CORE_ADDR_DOWNLOAD   32'h0000_0000
`define CORE_ADDR_ROM_SIZE   32'h0000_0004
`define CORE_ADDR_ROM_TYPE   32'h0000_0008
`define CORE_ADDR_RAM_SIZE   32'h0000_000C
`define CORE_ADDR_PAL        32'h0000_0010
`define CORE_ADDR_RESET      32'h0000_0050
`define CORE_ADDR_MULTITAP   32'h0000_0100
`define CORE_ADDR_LIGHTGUN   32'h0000_0104
`define CORE_ADDR_AIM_SPEED  32'h0000_0108
`define CORE_ADDR_VIDEO_4_3  32'h0000_0200

// soft reset hold-off, shortened for simulation
`define CORE_RESET_DELAY     32

// fractional pll reconfig sequence
`define PLL_RESET_CYCLES     20
`define PLL_ADDR_MODE        0
`define PLL_ADDR_MIF         31
`define PLL_ADDR_START       2

// save size entry in the data table
`define DATATABLE_SAVE_ADDR  3
`define SAVE_SIZE_UNIT       1024

// end-of-line slot word bits
`define VIDEO_SLOT_SNAP_BIT  14
`define VIDEO_SLOT_43_BIT    13

`endif
